// File: logic/apple1_config.svh
////////////////////
// build constants for the apple-1 memory and peripheral bus
// include once per compilation unit, the package pulls it in
////////////////////

`ifndef APPLE1_CONFIG_SVH
`define APPLE1_CONFIG_SVH

// ram banks
`define BANK_COUNT      5       // four low ram banks plus basic
`define BANK_ADDR_BITS  12      // 4 KB per bank
`define LOW_RAM_BANKS   4       // pages 0..3

// basic area sits in its own 4 KB page
`define BASIC_PAGE      4'hE

// cassette interface window
`define CASS_BASE       16'hC000
`define CASS_LAST       16'hC1FF

// tape monitor dac
`define DAC_BITS        16      // accumulator width, carry is extra

`endif

// File: logic/apple1_pkg.sv
////////////////////
// shared bus types for the apple-1 memory map
// import in the module body, scoped names in port lists
////////////////////

`include "apple1_config.svh"

package apple1_pkg;

	typedef logic [15:0]                  cpu_addr_t;   // 6502 address
	typedef logic [24:0]                  dl_addr_t;    // downloader address, 32 MB reach
	typedef logic [7:0]                   data_t;       // bus byte
	typedef logic [`BANK_ADDR_BITS-1:0]   bank_addr_t;  // offset inside a bank
	typedef logic [`BANK_COUNT-1:0]       bank_sel_t;   // one-hot bank select
	typedef logic [`DAC_BITS-1:0]         dac_word_t;   // delta-sigma input sample

	// memory map constants for the decoder and the read path
	localparam int        BANK_COUNT    = `BANK_COUNT;
	localparam int        LOW_RAM_BANKS = `LOW_RAM_BANKS;
	localparam logic [3:0] BASIC_PAGE   = `BASIC_PAGE;
	localparam cpu_addr_t CASS_BASE     = `CASS_BASE;
	localparam cpu_addr_t CASS_LAST     = `CASS_LAST;

endpackage

// File: logic/bus_arbiter.sv
////////////////////
// bus master select between the cpu and the rom downloader
// registers the winning access and decodes the memory map
// download writes win, the cpu strobe is masked meanwhile
////////////////////

`timescale 1ns/1ns

module bus_arbiter (
	input  logic                   sys_clock,
	input  logic                   rst_i,
	// cpu side
	input  apple1_pkg::cpu_addr_t  cpu_addr_i,
	input  apple1_pkg::data_t      cpu_wdata_i,
	input  logic                   cpu_wr_i,
	input  logic                   cpu_clken_i,
	// downloader side
	input  logic                   download_active_i,
	input  apple1_pkg::dl_addr_t   download_addr_i,
	input  apple1_pkg::data_t      download_data_i,
	input  logic                   download_wr_i,
	// gated strobe back to the cpu
	output logic                   cpu_clken_o,
	output logic                   led_o,
	// registered bus
	output apple1_pkg::bank_addr_t bus_addr_o,
	output apple1_pkg::data_t      bus_wdata_o,
	output logic                   bus_we_o,
	output logic                   bus_access_o,
	output apple1_pkg::bank_sel_t  bank_sel_o,
	output logic                   cass_sel_o
);
	import apple1_pkg::*;

	localparam int AW = $bits(bank_addr_t);  // in-bank address bits
	localparam int PW = 16 - AW;             // page number bits

	logic          dl_take;     // download write owns this cycle
	logic          cpu_strobe;  // cpu enable with download masking
	dl_addr_t      next_addr;
	data_t         next_wdata;
	logic          next_we;
	logic          next_access;
	logic          in_64k;      // nothing above 0xFFFF is mapped
	logic [PW-1:0] page;
	bank_sel_t     next_sel;
	logic          next_cass;

	assign dl_take     = download_active_i & download_wr_i;
	assign cpu_strobe  = cpu_clken_i & ~download_active_i;  // cpu frozen while downloading
	assign cpu_clken_o = cpu_strobe;
	assign led_o       = ~dl_take;  // led blinks off on each download write

	// master mux
	assign next_addr   = dl_take ? download_addr_i : dl_addr_t'(cpu_addr_i);
	assign next_wdata  = dl_take ? download_data_i : cpu_wdata_i;
	assign next_we     = dl_take | (cpu_wr_i & cpu_strobe);
	assign next_access = dl_take | cpu_strobe;

	// decode on the full downloader width
	assign in_64k    = (next_addr[$bits(dl_addr_t)-1:16] == '0);
	assign page      = next_addr[15:AW];
	assign next_cass = (next_addr >= dl_addr_t'(CASS_BASE)) &&
		(next_addr <= dl_addr_t'(CASS_LAST));  // 0xC000..0xC1FF

	always_comb begin
		next_sel = '0;
		for (int i = 0; i < BANK_COUNT; i++) begin
			if (i < LOW_RAM_BANKS) begin
				next_sel[i] = in_64k && (page == PW'(i));  // low ram, one page each
			end else begin
				// banks past low ram stack up from the basic page
				next_sel[i] = in_64k && (page == PW'(BASIC_PAGE) + PW'(i - LOW_RAM_BANKS));
			end
		end
	end

	// payload, no reset
	always_ff @(posedge sys_clock) begin
		bus_addr_o  <= next_addr[AW-1:0];
		bus_wdata_o <= next_wdata;
	end

	// control, cleared on reset
	always_ff @(posedge sys_clock) begin
		if (rst_i) begin
			bus_we_o     <= 1'b0;
			bus_access_o <= 1'b0;
			bank_sel_o   <= '0;
			cass_sel_o   <= 1'b0;
		end else begin
			bus_we_o     <= next_we;
			bus_access_o <= next_access;
			bank_sel_o   <= next_sel;   // selects follow the address every cycle for reads
			cass_sel_o   <= next_cass;
		end
	end

endmodule

// File: logic/mem_bank.sv
////////////////////
// one 4 KB ram bank, single port, read-first
// read data is registered every cycle
////////////////////

`timescale 1ns/1ns

module mem_bank (
	input  logic                   sys_clock,
	input  apple1_pkg::bank_addr_t addr_i,
	input  apple1_pkg::data_t      wdata_i,
	input  logic                   we_i,
	output apple1_pkg::data_t      rdata_o
);
	import apple1_pkg::*;

	localparam int DEPTH = 1 << $bits(bank_addr_t);  // 4096 bytes

	data_t mem [DEPTH];  // maps onto block ram

	always_ff @(posedge sys_clock) begin
		if (we_i) begin
			mem[addr_i] <= wdata_i;
		end
		rdata_o <= mem[addr_i];  // old data on a same-address write
	end

endmodule

// File: logic/read_mux.sv
////////////////////
// drain multiplexer for the bank read ports
// unmapped addresses read back 0x00
////////////////////

`timescale 1ns/1ns

module read_mux (
	input  logic                  sys_clock,
	input  logic                  rst_i,
	input  apple1_pkg::bank_sel_t bank_sel_i,
	input  apple1_pkg::data_t     bank_rdata_i [apple1_pkg::BANK_COUNT],
	output apple1_pkg::data_t     cpu_rdata_o
);
	import apple1_pkg::*;

	bank_sel_t sel_q;      // select aligned with bank read data
	data_t     rdata_sel;

	always_ff @(posedge sys_clock) begin
		if (rst_i) begin
			sel_q <= '0;
		end else begin
			sel_q <= bank_sel_i;
		end
	end

	// and-or mux, select is one-hot or empty
	always_comb begin
		rdata_sel = '0;
		for (int i = 0; i < BANK_COUNT; i++) begin
			if (sel_q[i]) begin
				rdata_sel = rdata_sel | bank_rdata_i[i];
			end
		end
	end

	always_ff @(posedge sys_clock) begin
		if (rst_i) begin
			cpu_rdata_o <= '0;
		end else begin
			cpu_rdata_o <= rdata_sel;  // 0x00 when no bank hit
		end
	end

endmodule

// File: logic/tape_audio.sv
////////////////////
// cassette interface flip-flop and tape monitor audio
// monitor bit goes through a first order delta-sigma dac to both pins
////////////////////

`timescale 1ns/1ns

module tape_audio (
	input  logic sys_clock,
	input  logic rst_i,
	input  logic bus_access_i,
	input  logic cass_sel_i,
	input  logic tape_rx_i,          // audio in from the board, active low
	input  logic monitor_tape_in_i,  // 1 listens to tape in, 0 to tape out
	output logic tape_out_o,
	output logic audio_l_o,
	output logic audio_r_o
);
	import apple1_pkg::*;

	localparam int DW = $bits(dac_word_t);

	logic          cass_hit_q;   // access strobe, one stage
	logic          cas_in;       // latched tape input
	logic          monitor_bit;
	dac_word_t     dac_in;
	logic [DW:0]   dac_acc;      // msb is the carry out

	// any cassette access flips the output
	always_ff @(posedge sys_clock) begin
		if (rst_i) begin
			cass_hit_q <= 1'b0;
			tape_out_o <= 1'b0;
		end else begin
			cass_hit_q <= bus_access_i & cass_sel_i;
			tape_out_o <= tape_out_o ^ cass_hit_q;
		end
	end

	// input sampler
	always_ff @(posedge sys_clock) begin
		cas_in <= ~tape_rx_i;  // rx pin idles high
	end

	assign monitor_bit = monitor_tape_in_i ? cas_in : tape_out_o;

	// 1-bit sample at full scale half
	always_comb begin
		dac_in         = '0;
		dac_in[DW-1]   = monitor_bit;
	end

	// accumulate and keep the carry
	always_ff @(posedge sys_clock) begin
		if (rst_i) begin
			dac_acc <= '0;
		end else begin
			dac_acc <= {1'b0, dac_acc[DW-1:0]} + {1'b0, dac_in};
		end
	end

	// same mono stream on both channels
	assign audio_l_o = dac_acc[DW];
	assign audio_r_o = dac_acc[DW];

endmodule

// File: logic/reset_ctrl.sv
////////////////////
// cpu reset merge
// keyboard reset key counts on its rising edge only
////////////////////

`timescale 1ns/1ns

module reset_ctrl (
	input  logic sys_clock,
	input  logic rst_i,
	input  logic menu_reset_i,    // osd menu entry, level
	input  logic reset_button_i,  // board button, level
	input  logic reset_key_i,     // keyboard shortcut, may stay held
	output logic cpu_reset_o
);

	logic key_q;     // previous key sample
	logic key_rise;

	// single pulse per press so a held key does not keep the cpu in reset
	assign key_rise = reset_key_i & ~key_q;

	always_ff @(posedge sys_clock) begin
		if (rst_i) begin
			key_q       <= 1'b0;
			cpu_reset_o <= 1'b1;  // cpu held for the whole system reset
		end else begin
			key_q       <= reset_key_i;
			cpu_reset_o <= menu_reset_i | reset_button_i | key_rise;
		end
	end

endmodule

// File: logic/apple1_bus_top.sv
////////////////////
// apple-1 memory and peripheral bus top
// cpu and downloader attach through loose bus ports
// five ram banks, cassette audio and reset merge
////////////////////

`timescale 1ns/1ns

`include "apple1_config.svh"

module apple1_bus_top (
	input  logic                  sys_clock,
	input  logic                  rst_i,
	// cpu bus
	input  apple1_pkg::cpu_addr_t cpu_addr_i,
	input  apple1_pkg::data_t     cpu_wdata_i,
	input  logic                  cpu_wr_i,
	input  logic                  cpu_clken_i,
	output logic                  cpu_clken_o,
	output apple1_pkg::data_t     cpu_rdata_o,
	// rom/program downloader
	input  logic                  download_active_i,
	input  apple1_pkg::dl_addr_t  download_addr_i,
	input  apple1_pkg::data_t     download_data_i,
	input  logic                  download_wr_i,
	output logic                  led_o,
	// cassette and audio
	input  logic                  tape_rx_i,
	input  logic                  monitor_tape_in_i,
	output logic                  tape_out_o,
	output logic                  audio_l_o,
	output logic                  audio_r_o,
	// reset sources
	input  logic                  menu_reset_i,
	input  logic                  reset_button_i,
	input  logic                  reset_key_i,
	output logic                  cpu_reset_o
);

	// registered bus from the arbiter
	apple1_pkg::bank_addr_t bus_addr;
	apple1_pkg::data_t      bus_wdata;
	logic                   bus_we;
	logic                   bus_access;
	apple1_pkg::bank_sel_t  bank_sel;
	logic                   cass_sel;
	apple1_pkg::data_t      bank_rdata [`BANK_COUNT];  // one read port per bank

	bus_arbiter u_arbiter (
		.sys_clock         (sys_clock),
		.rst_i             (rst_i),
		.cpu_addr_i        (cpu_addr_i),
		.cpu_wdata_i       (cpu_wdata_i),
		.cpu_wr_i          (cpu_wr_i),
		.cpu_clken_i       (cpu_clken_i),
		.download_active_i (download_active_i),
		.download_addr_i   (download_addr_i),
		.download_data_i   (download_data_i),
		.download_wr_i     (download_wr_i),
		.cpu_clken_o       (cpu_clken_o),
		.led_o             (led_o),
		.bus_addr_o        (bus_addr),
		.bus_wdata_o       (bus_wdata),
		.bus_we_o          (bus_we),
		.bus_access_o      (bus_access),
		.bank_sel_o        (bank_sel),
		.cass_sel_o        (cass_sel)
	);

	// low ram pages 0..3 then basic at page E
	for (genvar i = 0; i < `BANK_COUNT; i++) begin : g_bank
		mem_bank u_bank (
			.sys_clock (sys_clock),
			.addr_i    (bus_addr),
			.wdata_i   (bus_wdata),
			.we_i      (bus_we & bank_sel[i]),  // own select only
			.rdata_o   (bank_rdata[i])
		);
	end

	read_mux u_read_mux (
		.sys_clock    (sys_clock),
		.rst_i        (rst_i),
		.bank_sel_i   (bank_sel),
		.bank_rdata_i (bank_rdata),
		.cpu_rdata_o  (cpu_rdata_o)
	);

	tape_audio u_tape_audio (
		.sys_clock         (sys_clock),
		.rst_i             (rst_i),
		.bus_access_i      (bus_access),
		.cass_sel_i        (cass_sel),
		.tape_rx_i         (tape_rx_i),
		.monitor_tape_in_i (monitor_tape_in_i),
		.tape_out_o        (tape_out_o),
		.audio_l_o         (audio_l_o),
		.audio_r_o         (audio_r_o)
	);

	reset_ctrl u_reset_ctrl (
		.sys_clock      (sys_clock),
		.rst_i          (rst_i),
		.menu_reset_i   (menu_reset_i),
		.reset_button_i (reset_button_i),
		.reset_key_i    (reset_key_i),
		.cpu_reset_o    (cpu_reset_o)
	);

endmodule

// File: testbench/tb_apple1_bus.sv
////////////////////
// testbench for the apple-1 bus top
// runs reset, memory map, download, cassette, audio and reset source checks
////////////////////

`timescale 1ns/1ns

module tb_apple1_bus;
	import apple1_pkg::*;

	localparam int CLK_PERIOD    = 100;
	localparam int RST_CYCLES    = 10;
	// cycle budget per test in run order
	localparam int TEST_CYCLES   = 20 + 280 + 140 + 80 + 60 + 200 + 60;
	localparam int MARGIN_CYCLES = 300;

	logic      sys_clock;
	logic      rst_i;
	cpu_addr_t cpu_addr_i;
	data_t     cpu_wdata_i;
	logic      cpu_wr_i;
	logic      cpu_clken_i;
	logic      cpu_clken_o;
	data_t     cpu_rdata_o;
	logic      download_active_i;
	dl_addr_t  download_addr_i;
	data_t     download_data_i;
	logic      download_wr_i;
	logic      led_o;
	logic      tape_rx_i;
	logic      monitor_tape_in_i;
	logic      tape_out_o;
	logic      audio_l_o;
	logic      audio_r_o;
	logic      menu_reset_i;
	logic      reset_button_i;
	logic      reset_key_i;
	logic      cpu_reset_o;

	// reference model
	data_t       ref_mem [int];  // expected byte per cpu address
	int          cass_count = 0; // gated cassette accesses so far
	cpu_addr_t   bank_addrs [$];
	logic [3:0]  pages [5]      = '{4'h0, 4'h1, 4'h2, 4'h3, 4'hE};
	logic [11:0] iso_offs [3]   = '{12'h000, 12'h800, 12'hF00};
	cpu_addr_t   unmapped [4]   = '{16'h4000, 16'h8000, 16'hC800, 16'hFF00};
	int unsigned seed           = 69;
	int          err_count      = 0;
	int          test_err_start = 0;
	int          pass_count     = 0;
	int          fail_count     = 0;
	string       cur_test       = "none";

	apple1_bus_top UUT (.*);

	initial sys_clock = 1'b0;
	always #(CLK_PERIOD / 2) sys_clock = ~sys_clock;

	// ram sits in pages 0..3 and page E
	function automatic logic is_mapped(input cpu_addr_t addr);
		return (addr[15:12] < 4'h4) || (addr[15:12] == 4'hE);
	endfunction

	function automatic logic in_cass(input cpu_addr_t addr);
		return (addr >= 16'hC000) && (addr <= 16'hC1FF);
	endfunction

	task automatic check_value(
		input string       what,
		input logic [31:0] exp,
		input logic [31:0] act
	);
		assert (act === exp) else begin
			$display("FAILED %s: %s expected %0h actual %0h", cur_test, what, exp, act);
			err_count++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test       = name;
		test_err_start = err_count;
	endtask

	task automatic end_test();
		if (err_count == test_err_start) begin
			pass_count++;
			$display("test %s: ok", cur_test);
		end else begin
			fail_count++;
			$display("test %s: %0d errors", cur_test, err_count - test_err_start);
		end
	endtask

	// one strobed cpu cycle and the address stays on the bus
	task automatic cpu_cycle(input cpu_addr_t addr, input data_t data, input logic wr);
		@(posedge sys_clock);
		cpu_addr_i  <= addr;
		cpu_wdata_i <= data;
		cpu_wr_i    <= wr;
		cpu_clken_i <= 1'b1;
		if (!download_active_i) begin  // cpu lost while downloading
			if (wr && is_mapped(addr)) begin
				ref_mem[addr] = data;
			end
			if (in_cass(addr)) begin
				cass_count++;
			end
		end
		@(posedge sys_clock);
		cpu_wr_i    <= 1'b0;
		cpu_clken_i <= 1'b0;
	endtask

	// data lands two edges after the sampling edge
	task automatic read_check(input cpu_addr_t addr);
		data_t exp;
		exp = is_mapped(addr) ? ref_mem[addr] : 8'h00;
		cpu_cycle(addr, 8'h00, 1'b0);
		repeat (2) @(posedge sys_clock);
		@(negedge sys_clock);
		check_value($sformatf("cpu_rdata_o @%h", addr), exp, cpu_rdata_o);
	endtask

	task automatic dl_write(input dl_addr_t addr, input data_t data);
		@(posedge sys_clock);
		download_addr_i <= addr;
		download_data_i <= data;
		download_wr_i   <= 1'b1;
		if (addr <= 25'h00FFFF) begin  // nothing above 64 KB
			if (is_mapped(addr[15:0])) begin
				ref_mem[addr[15:0]] = data;
			end
			if (in_cass(addr[15:0])) begin
				cass_count++;
			end
		end
		@(negedge sys_clock);
		check_value("led_o in download write", 0, led_o);
		@(posedge sys_clock);
		download_wr_i <= 1'b0;
		@(negedge sys_clock);
		check_value("led_o after download write", 1, led_o);
	endtask

	task automatic cass_check(input cpu_addr_t addr, input logic wr);
		cpu_cycle(addr, 8'hC3, wr);
		repeat (2) @(posedge sys_clock);  // toggle two edges after sampling
		@(negedge sys_clock);
		check_value($sformatf("tape_out_o after %h", addr), cass_count[0], tape_out_o);
	endtask

	task automatic audio_window(input logic mon, input logic rx);
		int   ones;
		logic bit_exp;
		@(posedge sys_clock);
		monitor_tape_in_i <= mon;
		tape_rx_i         <= rx;
		bit_exp = mon ? ~rx : cass_count[0];  // inverted rx or tape out
		repeat (4) @(posedge sys_clock);
		ones = 0;
		repeat (32) begin
			@(negedge sys_clock);
			check_value("audio_r_o vs audio_l_o", audio_l_o, audio_r_o);
			ones += audio_l_o;
		end
		check_value($sformatf("audio ones for bit %b", bit_exp), bit_exp ? 16 : 0, ones);
	endtask

	// src 0 picks the menu reset and 1 the board button
	task automatic level_reset(input int src);
		@(posedge sys_clock);
		if (src == 0) menu_reset_i <= 1'b1;
		else reset_button_i <= 1'b1;
		@(posedge sys_clock);
		repeat (5) begin
			@(negedge sys_clock);
			check_value("cpu_reset_o held", 1, cpu_reset_o);
		end
		@(posedge sys_clock);
		menu_reset_i   <= 1'b0;
		reset_button_i <= 1'b0;
		@(posedge sys_clock);
		@(negedge sys_clock);
		check_value("cpu_reset_o released", 0, cpu_reset_o);
	endtask

	task automatic key_press();
		int highs;
		@(posedge sys_clock);
		reset_key_i <= 1'b1;
		highs = 0;
		repeat (10) begin  // key stays held the whole window
			@(negedge sys_clock);
			highs += cpu_reset_o;
		end
		check_value("cpu_reset_o pulse cycles", 1, highs);
		@(posedge sys_clock);
		reset_key_i <= 1'b0;
		repeat (2) @(posedge sys_clock);
	endtask

	// gating and led rules hold on every cycle
	always @(negedge sys_clock) begin
		if (!rst_i) begin
			check_value("cpu_clken_o", download_active_i ? 1'b0 : cpu_clken_i, cpu_clken_o);
			check_value("led_o", (download_active_i && download_wr_i) ? 1'b0 : 1'b1, led_o);
			check_value("audio_r_o", audio_l_o, audio_r_o);
		end
	end

	initial begin
		#(CLK_PERIOD * (TEST_CYCLES + MARGIN_CYCLES));
		$display("timeout: the tests did not finish within %0d cycles",
			TEST_CYCLES + MARGIN_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		cpu_addr_t   addr;
		logic [31:0] rnd;
		void'($urandom(seed));
		rst_i             = 1'b1;
		cpu_addr_i        = '0;
		cpu_wdata_i       = '0;
		cpu_wr_i          = 1'b0;
		cpu_clken_i       = 1'b0;
		download_active_i = 1'b0;
		download_addr_i   = '0;
		download_data_i   = '0;
		download_wr_i     = 1'b0;
		tape_rx_i         = 1'b1;  // idle line
		monitor_tape_in_i = 1'b0;
		menu_reset_i      = 1'b0;
		reset_button_i    = 1'b0;
		reset_key_i       = 1'b0;

		start_test("reset_values");
		repeat (RST_CYCLES - 1) begin
			@(posedge sys_clock);
			@(negedge sys_clock);
			check_value("cpu_reset_o in reset", 1, cpu_reset_o);
		end
		@(posedge sys_clock);
		rst_i <= 1'b0;
		@(negedge sys_clock);
		check_value("led_o", 1, led_o);
		check_value("cpu_rdata_o", 0, cpu_rdata_o);
		check_value("tape_out_o", 0, tape_out_o);
		check_value("audio_l_o", 0, audio_l_o);
		check_value("audio_r_o", 0, audio_r_o);
		check_value("dac accumulator", 0, UUT.u_tape_audio.dac_acc);
		@(negedge sys_clock);
		check_value("cpu_reset_o after reset", 0, cpu_reset_o);
		end_test();

		start_test("bank_rw");
		foreach (pages[p]) begin
			repeat (8) begin
				rnd  = $urandom;
				addr = {pages[p], rnd[11:0]};
				bank_addrs.push_back(addr);
				cpu_cycle(addr, rnd[19:12], 1'b1);
			end
		end
		foreach (bank_addrs[i]) begin
			read_check(bank_addrs[i]);
		end
		end_test();

		start_test("unmapped");
		foreach (pages[p]) begin
			foreach (iso_offs[o]) begin
				rnd = $urandom;
				cpu_cycle({pages[p], iso_offs[o]}, rnd[7:0], 1'b1);
			end
		end
		foreach (unmapped[u]) begin
			rnd = $urandom;
			cpu_cycle(unmapped[u], rnd[7:0], 1'b1);  // must hit no bank
			read_check(unmapped[u]);
		end
		foreach (pages[p]) begin
			foreach (iso_offs[o]) begin
				read_check({pages[p], iso_offs[o]});
			end
		end
		end_test();

		start_test("download");
		cpu_cycle(16'h0123, 8'h5A, 1'b1);
		cpu_cycle(16'hE456, 8'hA5, 1'b1);
		@(posedge sys_clock);
		download_active_i <= 1'b1;
		cpu_clken_i       <= 1'b1;
		@(negedge sys_clock);
		check_value("cpu_clken_o during download", 0, cpu_clken_o);
		cpu_cycle(16'h0123, 8'hFF, 1'b1);  // cpu write is lost
		rnd = $urandom;
		dl_write(25'h0002345, rnd[7:0]);
		dl_write(25'h000E789, rnd[15:8]);
		dl_write(25'h0003001, rnd[23:16]);
		dl_write(25'h0010123, 8'h33);  // above 64 KB so no write
		dl_write(25'h001E456, 8'h44);
		@(posedge sys_clock);
		download_active_i <= 1'b0;
		read_check(16'h0123);
		read_check(16'hE456);
		read_check(16'h2345);
		read_check(16'hE789);
		read_check(16'h3001);
		end_test();

		start_test("cassette");
		cass_check(16'hC000, 1'b0);
		cass_check(16'hC1FF, 1'b0);
		cass_check(16'hC0A5, 1'b1);
		cass_check(16'hBFFF, 1'b0);
		cass_check(16'hC200, 1'b0);
		cass_check(16'hC100, 1'b0);
		@(posedge sys_clock);
		download_active_i <= 1'b1;
		cass_check(16'hC010, 1'b0);  // gated off so no toggle
		@(posedge sys_clock);
		download_active_i <= 1'b0;
		end_test();

		start_test("audio");
		audio_window(1'b1, 1'b0);
		audio_window(1'b1, 1'b1);
		audio_window(1'b0, 1'b1);
		cass_check(16'hC020, 1'b0);
		audio_window(1'b0, 1'b1);
		end_test();

		start_test("reset_sources");
		key_press();
		key_press();
		level_reset(0);
		level_reset(1);
		end_test();

		$display("tests passed %0d, failed %0d, errors %0d", pass_count, fail_count, err_count);
		if (fail_count == 0 && err_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: sources.f
+incdir+logic
logic/apple1_pkg.sv
logic/bus_arbiter.sv
logic/mem_bank.sv
logic/read_mux.sv
logic/tape_audio.sv
logic/reset_ctrl.sv
logic/apple1_bus_top.sv
testbench/tb_apple1_bus.sv

// File: Bender.yml
package:
  name: apple1_bus

sources:
  - include_dirs:
      - logic
    files:
      - logic/apple1_pkg.sv
      - logic/bus_arbiter.sv
      - logic/mem_bank.sv
      - logic/read_mux.sv
      - logic/tape_audio.sv
      - logic/reset_ctrl.sv
      - logic/apple1_bus_top.sv
  - target: simulation
    files:
      - testbench/tb_apple1_bus.sv
